//--- files.f
+incdir+include
hdl/sensor_pkg.sv
hdl/sample_buffer.sv
hdl/sensor_ctrl.sv
hdl/sctrl_bus_ctrl.sv
hdl/sctrl_top.sv
tb/sctrl_tb.sv

//--- hdl/sample_buffer.sv
`timescale 1ns/100ps
`include "sensor_settings.svh"

module sample_buffer (
    input  logic                          clk,

    // Write port from the sequencer
    input  sensor_pkg::buf_wr_t           wr,

    // Read port to the bus controller
    input  logic [`SENSOR_BUF_AW-1:0]     rd_addr,
    output logic [`SENSOR_DATA_BITS-1:0]  rd_data
);
    logic [`SENSOR_DATA_BITS-1:0] mem [`SENSOR_BUF_DEPTH];

    // Contents are undefined until written
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Asynchronous read
    assign rd_data = mem[rd_addr];

endmodule

//--- hdl/sctrl_bus_ctrl.sv
`timescale 1ns/100ps
`include "sensor_settings.svh"

module sctrl_bus_ctrl (
    input  logic                          clk,
    input  logic                          rst,

    // Write address
    input  logic [`SENSOR_ID_BITS-1:0]    awid,
    input  logic [`SENSOR_ADDR_BITS-1:0]  awaddr,
    input  logic                          awvalid,
    output logic                          awready,

    // Write data
    input  logic [`SENSOR_DATA_BITS-1:0]  wdata,
    input  logic                          wlast,
    input  logic                          wvalid,
    output logic                          wready,

    // Write response
    output logic [`SENSOR_ID_BITS-1:0]    bid,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,

    // Read address
    input  logic [`SENSOR_ID_BITS-1:0]    arid,
    input  logic [`SENSOR_ADDR_BITS-1:0]  araddr,
    input  logic                          arvalid,
    output logic                          arready,

    // Read data
    output logic [`SENSOR_ID_BITS-1:0]    rid,
    output logic [`SENSOR_DATA_BITS-1:0]  rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast,
    output logic                          rvalid,
    input  logic                          rready,

    // Sequencer and buffer side
    output sensor_pkg::sctrl_cmd_t        cmd,
    output logic [`SENSOR_BUF_AW-1:0]     rd_addr,
    input  logic [`SENSOR_DATA_BITS-1:0]  rd_data
);
    import sensor_pkg::*;

    typedef enum logic [2:0] {IDLE, AR, R, AW, W, B} state_t;

    state_t   state;
    state_t   next_state;

    bus_req_t aw_req;
    bus_req_t ar_req;

    logic     aw_fire;
    logic     w_fire;
    logic     ar_fire;
    logic     r_fire;
    logic     b_fire;

    // Handshakes
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign b_fire  = bvalid && bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // One transaction at a time, writes win in IDLE
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (awvalid) begin
                    next_state = AW;
                end else if (arvalid) begin
                    next_state = AR;
                end
            end
            AR: begin
                if (ar_fire) begin
                    next_state = R;
                end
            end
            R: begin
                if (r_fire) begin
                    next_state = IDLE;
                end
            end
            AW: begin
                if (aw_fire) begin
                    next_state = W;
                end
            end
            W: begin
                if (w_fire && wlast) begin
                    next_state = B;
                end
            end
            B: begin
                if (b_fire) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Request capture, payload only
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_req.id   <= awid;
            aw_req.addr <= awaddr;
        end
        if (ar_fire) begin
            ar_req.id   <= arid;
            ar_req.addr <= araddr;
        end
    end

    // Command registers, written with the OR of the data word
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.en    <= 1'b0;
            cmd.clear <= 1'b0;
        end else if (state == W && w_fire && wlast) begin
            if (aw_req.addr[15:0] == `SENSOR_REG_EN) begin
                cmd.en <= |wdata;
            end
            if (aw_req.addr[15:0] == `SENSOR_REG_CLEAR) begin
                cmd.clear <= |wdata;
            end
        end
    end

    // Channel outputs decoded from the state
    assign awready = (state == AW);
    assign wready  = (state == W) && wvalid;
    assign arready = (state == AR);

    assign bvalid  = (state == B);
    assign bid     = aw_req.id;
    // Always OKAY
    assign bresp   = 2'b00;

    assign rvalid  = (state == R);
    assign rlast   = (state == R);
    assign rid     = ar_req.id;
    assign rresp   = 2'b00;

    // Word address into the buffer
    assign rd_addr = ar_req.addr[`SENSOR_BUF_AW+1:2];
    assign rdata   = (state == R) ? rd_data : '0;

endmodule

//--- hdl/sctrl_top.sv
`timescale 1ns/100ps
`include "sensor_settings.svh"

module sctrl_top (
    input  logic                          clk,
    input  logic                          rst,

    // Write address
    input  logic [`SENSOR_ID_BITS-1:0]    awid,
    input  logic [`SENSOR_ADDR_BITS-1:0]  awaddr,
    input  logic [3:0]                    awlen,
    input  logic [2:0]                    awsize,
    input  logic [1:0]                    awburst,
    input  logic                          awvalid,
    output logic                          awready,

    // Write data
    input  logic [`SENSOR_DATA_BITS-1:0]  wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wlast,
    input  logic                          wvalid,
    output logic                          wready,

    // Write response
    output logic [`SENSOR_ID_BITS-1:0]    bid,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,

    // Read address
    input  logic [`SENSOR_ID_BITS-1:0]    arid,
    input  logic [`SENSOR_ADDR_BITS-1:0]  araddr,
    input  logic [3:0]                    arlen,
    input  logic [2:0]                    arsize,
    input  logic [1:0]                    arburst,
    input  logic                          arvalid,
    output logic                          arready,

    // Read data
    output logic [`SENSOR_ID_BITS-1:0]    rid,
    output logic [`SENSOR_DATA_BITS-1:0]  rdata,
    output logic [1:0]                    rresp,
    output logic                          rlast,
    output logic                          rvalid,
    input  logic                          rready,

    // Sensor side, burst fields above are single beat only
    output logic                          sctrl_interrupt,
    input  logic                          sensor_ready,
    input  logic [`SENSOR_DATA_BITS-1:0]  sensor_out,
    output logic                          sensor_en
);
    import sensor_pkg::*;

    sctrl_cmd_t                   cmd;
    buf_wr_t                      wr;
    logic [`SENSOR_BUF_AW-1:0]    rd_addr;
    logic [`SENSOR_DATA_BITS-1:0] rd_data;

    sctrl_bus_ctrl i_sctrl_bus_ctrl (
        .clk     (clk),
        .rst     (rst),
        .awid    (awid),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .arid    (arid),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .cmd     (cmd),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    sensor_ctrl i_sensor_ctrl (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .sensor_ready    (sensor_ready),
        .sensor_out      (sensor_out),
        .sensor_en       (sensor_en),
        .sctrl_interrupt (sctrl_interrupt),
        .wr              (wr)
    );

    sample_buffer i_sample_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- hdl/sensor_ctrl.sv
`timescale 1ns/100ps
`include "sensor_settings.svh"

module sensor_ctrl (
    input  logic                          clk,
    input  logic                          rst,

    // Command flags from the bus controller
    input  sensor_pkg::sctrl_cmd_t        cmd,

    // Off-chip sensor
    input  logic                          sensor_ready,
    input  logic [`SENSOR_DATA_BITS-1:0]  sensor_out,
    output logic                          sensor_en,

    // Interrupt to the host
    output logic                          sctrl_interrupt,

    // Buffer write port
    output sensor_pkg::buf_wr_t           wr
);
    logic [`SENSOR_BUF_AW-1:0] count;
    logic                      full;
    logic                      store;
    logic                      last_word;

    // Sampling window, registers only
    assign sensor_en = cmd.en && !cmd.clear && !full;

    // A sample is accepted when the sensor answers while enabled
    assign store = sensor_en && sensor_ready;

    assign last_word = (count == {`SENSOR_BUF_AW{1'b1}});

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            full  <= 1'b0;
        end else if (cmd.clear) begin
            count <= '0;
            full  <= 1'b0;
        end else if (store) begin
            // Count wraps to zero as the last word lands
            count <= count + 1'b1;
            if (last_word) begin
                full <= 1'b1;
            end
        end
    end

    // Interrupt stays up until the host clears
    assign sctrl_interrupt = full;

    // Store goes to the buffer on the same edge
    always_comb begin
        wr.we   = store;
        wr.addr = count;
        wr.data = sensor_out;
    end

endmodule

//--- hdl/sensor_pkg.sv
`include "sensor_settings.svh"

package sensor_pkg;

    // Latched AW or AR request
    typedef struct packed {
        logic [`SENSOR_ID_BITS-1:0]   id;
        logic [`SENSOR_ADDR_BITS-1:0] addr;
    } bus_req_t;

    // Command flags from the bus side to the sequencer
    typedef struct packed {
        logic en;
        logic clear;
    } sctrl_cmd_t;

    // One sample store into the buffer
    typedef struct packed {
        logic                         we;
        logic [`SENSOR_BUF_AW-1:0]    addr;
        logic [`SENSOR_DATA_BITS-1:0] data;
    } buf_wr_t;

endpackage

//--- include/sensor_settings.svh
`ifndef SENSOR_SETTINGS_SVH
`define SENSOR_SETTINGS_SVH

// AXI field widths
`define SENSOR_ID_BITS      8
`define SENSOR_ADDR_BITS    32
`define SENSOR_DATA_BITS    32

// Sample buffer geometry
`define SENSOR_BUF_DEPTH    64
`define SENSOR_BUF_AW       6

// Command register offsets, low 16 address bits
// A nonzero write sets the flag, a zero write clears it
`define SENSOR_REG_EN       16'h0100
`define SENSOR_REG_CLEAR    16'h0200

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sensor controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module sctrl_tb \
    -o sctrl_sim > build.log 2>&1 \
    && ./obj_dir/sctrl_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- tb/sctrl_tb.sv
`timescale 1ns/100ps
`include "sensor_settings.svh"

module sctrl_tb;
    localparam int TIMEOUT = 2000;
    localparam int DEPTH   = `SENSOR_BUF_DEPTH;

    logic                         clk = 1'b0;
    logic                         rst = 1'b1;

    // Bus inputs start idle
    logic [`SENSOR_ID_BITS-1:0]   awid = '0;
    logic [`SENSOR_ADDR_BITS-1:0] awaddr = '0;
    logic [3:0]                   awlen = '0;
    logic [2:0]                   awsize = 3'd2;
    logic [1:0]                   awburst = 2'b01;
    logic                         awvalid = 1'b0;
    logic                         awready;
    logic [`SENSOR_DATA_BITS-1:0] wdata = '0;
    logic [3:0]                   wstrb = 4'hf;
    logic                         wlast = 1'b0;
    logic                         wvalid = 1'b0;
    logic                         wready;
    logic [`SENSOR_ID_BITS-1:0]   bid;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready = 1'b0;
    logic [`SENSOR_ID_BITS-1:0]   arid = '0;
    logic [`SENSOR_ADDR_BITS-1:0] araddr = '0;
    logic [3:0]                   arlen = '0;
    logic [2:0]                   arsize = 3'd2;
    logic [1:0]                   arburst = 2'b01;
    logic                         arvalid = 1'b0;
    logic                         arready;
    logic [`SENSOR_ID_BITS-1:0]   rid;
    logic [`SENSOR_DATA_BITS-1:0] rdata;
    logic [1:0]                   rresp;
    logic                         rlast;
    logic                         rvalid;
    logic                         rready = 1'b0;
    logic                         sctrl_interrupt;
    logic                         sensor_ready = 1'b0;
    logic [`SENSOR_DATA_BITS-1:0] sensor_out = '0;
    logic                         sensor_en;

    logic [31:0]                  rng = 32'hdfebeb78;
    int                           errors = 0;
    int                           timeouts = 0;

    // Reference model state
    logic                         m_en = 1'b0;
    logic                         m_clear = 1'b0;
    logic                         m_full = 1'b0;
    int                           m_stored = 0;
    logic [31:0]                  m_mem [DEPTH];
    logic [15:0]                  w_offset = '0;

    sctrl_top i_sctrl_top (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("FAILED %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic print_summary();
        $display("Done: %0d check errors, %0d timeouts", errors, timeouts);
    endtask

    task automatic abort_run(input string what);
        timeouts++;
        $display("Timeout: no %s after %0d clock cycles", what, TIMEOUT);
        print_summary();
        $display("sim failed");
        $finish;
    endtask

    // One clock of a bounded wait
    task automatic step(inout int n, input string what);
        @(posedge clk);
        n++;
        if (n > TIMEOUT) begin
            abort_run(what);
        end
    endtask

    task automatic write_reg(input logic [15:0] offset, input logic [31:0] data);
        logic [31:0]                r;
        logic [`SENSOR_ID_BITS-1:0] id;
        int                         n;
        r = next_rand();
        id = r[`SENSOR_ID_BITS-1:0];
        repeat (1 + int'(r[9:8])) @(posedge clk);
        awid    <= id;
        awaddr  <= {16'h0000, offset};
        awlen   <= r[19:16];
        awvalid <= 1'b1;
        n = 0;
        do step(n, "awready"); while (!awready);
        awvalid  <= 1'b0;
        w_offset = offset;
        wdata    <= data;
        wlast    <= 1'b1;
        wvalid   <= 1'b1;
        n = 0;
        do step(n, "wready"); while (!wready);
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        n = 0;
        do step(n, "bvalid"); while (!bvalid);
        // Back-pressure on the response
        repeat (int'(r[13:12])) @(posedge clk);
        bready <= 1'b1;
        n = 0;
        do step(n, "write response handshake"); while (!bvalid);
        assert (bid == id) else report_value("bid", 32'(bid), 32'(id));
        assert (bresp == 2'b00) else report_value("bresp", 32'(bresp), 32'h0);
        bready <= 1'b0;
    endtask

    task automatic read_word(input logic [5:0] idx);
        logic [31:0]                r;
        logic [`SENSOR_ID_BITS-1:0] id;
        int                         n;
        r = next_rand();
        id = r[`SENSOR_ID_BITS-1:0];
        repeat (1 + int'(r[9:8])) @(posedge clk);
        arid    <= id;
        araddr  <= {24'h000000, idx, 2'b00};
        arlen   <= r[19:16];
        arvalid <= 1'b1;
        n = 0;
        do step(n, "arready"); while (!arready);
        arvalid <= 1'b0;
        n = 0;
        do step(n, "rvalid"); while (!rvalid);
        repeat (int'(r[13:12])) @(posedge clk);
        rready <= 1'b1;
        n = 0;
        do step(n, "read data handshake"); while (!rvalid);
        assert (rdata === m_mem[idx])
            else report_value($sformatf("rdata of word %0d", idx), rdata, m_mem[idx]);
        assert (rid == id) else report_value("rid", 32'(rid), 32'(id));
        assert (rlast == 1'b1) else report_value("rlast", 32'(rlast), 32'h1);
        assert (rresp == 2'b00) else report_value("rresp", 32'(rresp), 32'h0);
        rready <= 1'b0;
    endtask

    // Whole buffer in shuffled order
    task automatic read_all();
        logic [5:0]  order [DEPTH];
        logic [5:0]  tmp;
        logic [31:0] r;
        int          i;
        int          j;
        for (i = 0; i < DEPTH; i++) begin
            order[i] = 6'(i);
        end
        for (i = DEPTH - 1; i > 0; i--) begin
            r = next_rand();
            j = int'(r % 32'(i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (i = 0; i < DEPTH; i++) begin
            read_word(order[i]);
        end
    endtask

    task automatic wait_for_interrupt();
        int n;
        n = 0;
        do step(n, "sctrl_interrupt"); while (!sctrl_interrupt);
    endtask

    // Model count is looked at on the falling edge
    task automatic wait_samples(input int target);
        int n;
        n = 0;
        do begin
            step(n, "mid-fill samples");
            @(negedge clk);
        end while (m_stored < target);
    endtask

    // Sensor model and reference model of the sequencer
    always @(posedge clk) begin
        logic        take;
        logic [31:0] r;
        take = m_en && !m_clear && !m_full && sensor_ready;
        if (rst) begin
            m_en = 1'b0;
            m_clear = 1'b0;
            m_full = 1'b0;
            m_stored = 0;
        end else begin
            if (m_clear) begin
                m_stored = 0;
                m_full = 1'b0;
            end else if (take) begin
                m_mem[m_stored] = sensor_out;
                m_stored++;
                if (m_stored == DEPTH) begin
                    m_full = 1'b1;
                end
            end
            // Command lands on the W handshake edge
            if (wvalid && wready && wlast) begin
                if (w_offset == `SENSOR_REG_EN) begin
                    m_en = |wdata;
                end
                if (w_offset == `SENSOR_REG_CLEAR) begin
                    m_clear = |wdata;
                end
            end
        end
        r = next_rand();
        sensor_ready <= (r[1:0] != 2'b00);
        sensor_out   <= next_rand();
    end

    always @(negedge clk) begin
        if (!rst) begin
            assert (sensor_en == (m_en && !m_clear && !m_full))
                else report_value("sensor_en", 32'(sensor_en),
                                  32'(m_en && !m_clear && !m_full));
            assert (sctrl_interrupt == m_full)
                else report_value("sctrl_interrupt", 32'(sctrl_interrupt), 32'(m_full));
        end
    end

    initial begin
        logic [31:0] r;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert ({awready, wready, bvalid, arready, rvalid, sensor_en, sctrl_interrupt} == 7'b0)
            else report_value("ready, valid, sensor_en and interrupt after reset",
                              {25'b0, awready, wready, bvalid, arready, rvalid,
                               sensor_en, sctrl_interrupt}, 32'h0);

        // First fill followed by extra sensor pulses while full
        write_reg(`SENSOR_REG_EN, next_rand() | 32'h1);
        wait_for_interrupt();
        repeat (20) @(posedge clk);
        read_all();

        // Clear drops the interrupt and its release refills from word 0
        write_reg(`SENSOR_REG_CLEAR, next_rand() | 32'h1);
        assert (!sctrl_interrupt) else report_value("sctrl_interrupt after clear",
                                                    32'(sctrl_interrupt), 32'h0);
        write_reg(`SENSOR_REG_CLEAR, 32'h0);
        wait_for_interrupt();
        read_all();

        // Clear in mid-fill restarts at word 0
        write_reg(`SENSOR_REG_CLEAR, 32'h1);
        write_reg(`SENSOR_REG_CLEAR, 32'h0);
        r = next_rand();
        wait_samples(4 + int'(r[2:0]));
        write_reg(`SENSOR_REG_CLEAR, 32'h1);
        write_reg(`SENSOR_REG_CLEAR, 32'h0);

        // Disable in mid-fill
        r = next_rand();
        wait_samples(8 + int'(r[4:0]));
        write_reg(`SENSOR_REG_EN, 32'h0);
        repeat (20) @(posedge clk);
        assert (!sctrl_interrupt) else report_value("sctrl_interrupt after disable",
                                                    32'(sctrl_interrupt), 32'h0);
        read_all();

        // Resume fills the rest of the buffer
        write_reg(`SENSOR_REG_EN, 32'h1);
        wait_for_interrupt();
        read_all();

        print_summary();
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
